/* list.f */
+incdir+src
src/lenet_data_pkg.sv
src/lenet_ctrl_pkg.sv
src/mac_lane_if.sv
src/approx_mult8.sv
src/mac_lane.sv
src/acc_combine.sv
src/lenet_mac_top.sv
tb/tb_lenet_mac.sv

/* run.sh */
#!/bin/sh
# Build and run the dot-product engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f list.f --top-module tb_lenet_mac -Mdir obj_dir -o sim_lenet_mac
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_lenet_mac
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

/* src/acc_combine.sv */
module acc_combine (
    input  logic                  clk,
    input  logic                  arst_n,
    mac_lane_if.comb              lane_a,
    mac_lane_if.comb              lane_b,
    output logic                  out_valid,
    output lenet_data_pkg::acc_t  out_sum
);

    lenet_ctrl_pkg::acc_state_t  state;
    lenet_data_pkg::acc_t        run_sum;   // Sum of the open window so far
    lenet_data_pkg::acc_t        beat_sum;  // Both lanes of the current beat
    lenet_data_pkg::acc_t        next_sum;

    // Lanes are loaded together, so lane_a strobes stand for both
    assign beat_sum = lenet_data_pkg::acc_t'(lane_a.product)
                    + lenet_data_pkg::acc_t'(lane_b.product);

    // First beat of a window starts from its own total
    assign next_sum = (state == lenet_ctrl_pkg::ACC_RUN) ? run_sum + beat_sum
                                                          : beat_sum;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= lenet_ctrl_pkg::ACC_IDLE;
            run_sum   <= '0;
            out_valid <= 1'b0;
            out_sum   <= '0;
        end else begin
            out_valid <= 1'b0;  // Single-cycle pulse
            if (lane_a.valid) begin
                run_sum <= next_sum;
                if (lane_a.last) begin
                    state     <= lenet_ctrl_pkg::ACC_IDLE;
                    out_valid <= 1'b1;
                    out_sum   <= next_sum;  // Held until the next window closes
                end else begin
                    state <= lenet_ctrl_pkg::ACC_RUN;
                end
            end
        end
    end

endmodule

/* src/approx_mult8.sv */
`include "lenet_settings.svh"

module approx_mult8 (
    input  lenet_data_pkg::pixel_t    x,
    input  lenet_data_pkg::weight_t   y,
    output lenet_data_pkg::product_t  z
);

    localparam int unsigned TERM_W = 13;  // Span of the compressed term words

    lenet_data_pkg::weight_t  row [`LENET_PIX_W];  // Partial-product rows
    logic [TERM_W-1:0]        w0;
    logic [TERM_W-1:0]        w1;
    logic [TERM_W-1:0]        w2;
    logic [TERM_W-1:0]        w3;
    logic [TERM_W-1:0]        w4;

    for (genvar i = 0; i < `LENET_PIX_W; i++) begin : g_row
        assign row[i] = y & {`LENET_PIX_W{x[i]}};
    end

    // Rows 0..5 reach the sum only through these terms and the rest is dropped
    always_comb begin
        w0     = '0;
        w0[1]  = row[0][1] | row[1][0];
        w0[3]  = row[0][2] | row[1][1];
        w0[5]  = row[0][5] ^ row[1][4];
        w0[6]  = row[0][5] & row[1][4];
        w0[7]  = row[4][2] & row[5][1];
        w0[8]  = row[4][3] | row[5][2];
        w0[9]  = row[2][6] | row[3][5];
        w0[10] = row[2][7] | row[3][6];
        w0[11] = row[4][7] ^ row[5][6];  // Sum bit of a half adder
        w0[12] = row[4][7] & row[5][6];  // Its carry
    end

    always_comb begin
        w1     = '0;
        w1[7]  = row[4][3] & row[5][2];
        w1[8]  = row[4][4] | row[5][3];
        w1[9]  = row[2][7] & row[3][6];
        w1[10] = row[3][7];
        w1[12] = row[5][7];
    end

    always_comb begin
        w2     = '0;
        w2[9]  = row[4][5] | row[5][4];
        w2[10] = row[4][5] & row[5][4];
    end

    always_comb begin
        w3     = '0;
        w3[10] = row[4][6] & row[5][5];
    end

    always_comb begin
        w4     = '0;
        w4[10] = row[4][6] ^ row[5][5];
    end

    // Two exact top rows plus the five term words wrap at product width
    assign z = lenet_data_pkg::product_t'({row[6], 6'b0})
             + lenet_data_pkg::product_t'({row[7], 7'b0})
             + lenet_data_pkg::product_t'(w0)
             + lenet_data_pkg::product_t'(w1)
             + lenet_data_pkg::product_t'(w2)
             + lenet_data_pkg::product_t'(w3)
             + lenet_data_pkg::product_t'(w4);

endmodule

/* src/lenet_ctrl_pkg.sv */
package lenet_ctrl_pkg;

    // Window tracking in the combiner
    typedef enum logic {
        ACC_IDLE = 1'b0,  // No window open
        ACC_RUN  = 1'b1   // First beat of a window seen
    } acc_state_t;

endpackage

/* src/lenet_data_pkg.sv */
`include "lenet_settings.svh"

package lenet_data_pkg;

    // Activation operand from the feature map
    typedef logic [`LENET_PIX_W-1:0] pixel_t;

    // Kernel weight operand
    typedef logic [`LENET_PIX_W-1:0] weight_t;

    // Approximate product of one lane
    typedef logic [`LENET_PROD_W-1:0] product_t;

    // Running sum and completed window sum
    typedef logic [`LENET_ACC_W-1:0] acc_t;

endpackage

/* src/lenet_mac_top.sv */
module lenet_mac_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  logic                     in_last,
    input  lenet_data_pkg::pixel_t   x0,
    input  lenet_data_pkg::weight_t  w0,
    input  lenet_data_pkg::pixel_t   x1,
    input  lenet_data_pkg::weight_t  w1,
    output logic                     out_valid,
    output lenet_data_pkg::acc_t     out_sum
);

    mac_lane_if lane_a (
        .clk (clk)
    );

    mac_lane_if lane_b (
        .clk (clk)
    );

    // First pixel/weight pair of the beat
    mac_lane lane0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_last  (in_last),
        .pixel    (x0),
        .weight   (w0),
        .lane     (lane_a)
    );

    // Second pair on the same strobes
    mac_lane lane1 (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_last  (in_last),
        .pixel    (x1),
        .weight   (w1),
        .lane     (lane_b)
    );

    acc_combine comb0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .lane_a    (lane_a),
        .lane_b    (lane_b),
        .out_valid (out_valid),
        .out_sum   (out_sum)
    );

endmodule

/* src/lenet_settings.svh */
`ifndef LENET_SETTINGS_SVH
`define LENET_SETTINGS_SVH

// Operand width shared by pixels and weights
`define LENET_PIX_W 8

// Full width of an 8x8 product
`define LENET_PROD_W 16

// Window sum where 127 beats of two products each fit without overflow
`define LENET_ACC_W 24

`endif

/* src/mac_lane.sv */
module mac_lane (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  logic                     in_last,
    input  lenet_data_pkg::pixel_t   pixel,
    input  lenet_data_pkg::weight_t  weight,
    mac_lane_if.lane                 lane
);

    lenet_data_pkg::product_t prod;  // Combinational product of this beat

    approx_mult8 mult0 (
        .x (pixel),
        .y (weight),
        .z (prod)
    );

    // Beat strobes one stage behind the input
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane.valid <= 1'b0;
            lane.last  <= 1'b0;
        end else begin
            lane.valid <= in_valid;
            lane.last  <= in_valid & in_last;  // Ignore last on idle cycles
        end
    end

    // Product only moves on a real beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane.product <= prod;
        end
    end

endmodule

/* src/mac_lane_if.sv */
interface mac_lane_if (
    input logic clk
);

    logic                      valid;    // Registered beat strobe
    logic                      last;     // Beat closes the window
    lenet_data_pkg::product_t  product;  // Registered approximate product

    modport lane (
        input  clk,
        output valid,
        output last,
        output product
    );

    modport comb (
        input  clk,
        input  valid,
        input  last,
        input  product
    );

endinterface

/* tb/tb_lenet_mac.sv */
module tb_lenet_mac;

    logic                     clk;
    logic                     arst_n;
    logic                     in_valid;
    logic                     in_last;
    lenet_data_pkg::pixel_t   x0;
    lenet_data_pkg::weight_t  w0;
    lenet_data_pkg::pixel_t   x1;
    lenet_data_pkg::weight_t  w1;
    logic                     out_valid;
    lenet_data_pkg::acc_t     out_sum;

    lenet_data_pkg::acc_t  expected_q [$];  // Window sums not yet seen at the output
    lenet_data_pkg::acc_t  exp_front;       // Head of expected_q held stable across posedge
    lenet_data_pkg::acc_t  run_total;       // Window being driven
    logic                  pop_pending;
    logic                  first_last_sent;
    logic                  exact_mode;      // Directed windows use true products
    int                    pulse_count;
    int                    windows_sent;
    logic [31:0]           rng_state = 32'd66;

    lenet_mac_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .x0        (x0),
        .w0        (w0),
        .x1        (x1),
        .w1        (w1),
        .out_valid (out_valid),
        .out_sum   (out_sum)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [15:0] place_bit(input logic b, input int pos);
        return {15'd0, b} << pos;
    endfunction

    // Reference product from exact rows 6 and 7 plus the compressed lower-row terms
    function automatic lenet_data_pkg::product_t model_product(
        input lenet_data_pkg::pixel_t  x,
        input lenet_data_pkg::weight_t w
    );
        logic [7:0]  r [8];
        logic [15:0] p;
        for (int i = 0; i < 8; i++) begin
            r[i] = w & {8{x[i]}};
        end
        p = {2'b0, r[6], 6'b0} + {1'b0, r[7], 7'b0};
        p = p + place_bit(r[0][1] | r[1][0], 1) + place_bit(r[0][2] | r[1][1], 3);
        p = p + place_bit(r[0][5] ^ r[1][4], 5) + place_bit(r[0][5] & r[1][4], 6);
        p = p + place_bit(r[4][2] & r[5][1], 7) + place_bit(r[4][3] | r[5][2], 8);
        p = p + place_bit(r[2][6] | r[3][5], 9) + place_bit(r[2][7] | r[3][6], 10);
        p = p + place_bit(r[4][7] ^ r[5][6], 11) + place_bit(r[4][7] & r[5][6], 12);
        p = p + place_bit(r[4][3] & r[5][2], 7) + place_bit(r[4][4] | r[5][3], 8);
        p = p + place_bit(r[2][7] & r[3][6], 9) + place_bit(r[3][7], 10);
        p = p + place_bit(r[5][7], 12);
        p = p + place_bit(r[4][5] | r[5][4], 9) + place_bit(r[4][5] & r[5][4], 10);
        p = p + place_bit(r[4][6] & r[5][5], 10) + place_bit(r[4][6] ^ r[5][5], 10);
        return p;
    endfunction

    function automatic lenet_data_pkg::acc_t beat_value(
        input lenet_data_pkg::pixel_t  x,
        input lenet_data_pkg::weight_t w
    );
        if (exact_mode) begin
            return lenet_data_pkg::acc_t'(x) * lenet_data_pkg::acc_t'(w);
        end
        return lenet_data_pkg::acc_t'(model_product(x, w));
    endfunction

    // A pulse is retired one negedge after it was seen so exp_front holds across its posedge
    task automatic track_outputs();
        if (pop_pending) begin
            void'(expected_q.pop_front());
            pop_pending = 1'b0;
        end
        if (out_valid) begin
            pop_pending = 1'b1;
            pulse_count++;
        end
    endtask

    task automatic drive_beat(
        input logic                    valid,
        input logic                    last,
        input lenet_data_pkg::pixel_t  a0,
        input lenet_data_pkg::weight_t b0,
        input lenet_data_pkg::pixel_t  a1,
        input lenet_data_pkg::weight_t b1
    );
        @(negedge clk);
        track_outputs();
        in_valid = valid;
        in_last  = last;
        x0       = a0;
        w0       = b0;
        x1       = a1;
        w1       = b1;
        if (valid) begin
            run_total = run_total + beat_value(a0, b0) + beat_value(a1, b1);
            if (last) begin
                expected_q.push_back(run_total);
                run_total       = '0;
                windows_sent++;
                first_last_sent = 1'b1;
            end
        end
        exp_front = (expected_q.size() > 0) ? expected_q[0] : '0;
    endtask

    task automatic idle_cycle();
        logic [31:0] r;
        r = next_random();
        drive_beat(1'b0, r[0], r[15:8], r[23:16], r[31:24], r[7:0]);  // Noise on idle inputs
    endtask

    task automatic send_window(input int beats, input int max_gap);
        logic [31:0] r;
        int          gap;
        for (int b = 0; b < beats; b++) begin
            if (max_gap > 0) begin
                r   = next_random();
                gap = int'(r % 32'(max_gap + 1));
                repeat (gap) idle_cycle();
            end
            r = next_random();
            drive_beat(1'b1, b == beats - 1, r[7:0], r[15:8], r[23:16], r[31:24]);
        end
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 || pop_pending) begin
            if (cycles >= limit) begin
                stop_on_error("Timed out waiting for the outstanding window sums");
            end else begin
                idle_cycle();
                cycles++;
            end
        end
    endtask

    no_early_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        !first_last_sent |-> !out_valid)
        else stop_on_error($sformatf("[FAIL] out_valid expected %h got %h",
                                     1'b0, $sampled(out_valid)));

    // Pulse exactly two edges after the last beat and never otherwise
    pulse_timing: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid && in_last, 2))
        else stop_on_error($sformatf("[FAIL] out_valid expected %h got %h",
                                     !$sampled(out_valid), $sampled(out_valid)));

    sum_value: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> out_sum == exp_front)
        else stop_on_error($sformatf("[FAIL] out_sum expected %h got %h",
                                     $sampled(exp_front), $sampled(out_sum)));

    initial begin
        logic [31:0] r;
        arst_n          = 1'b0;
        in_valid        = 1'b0;
        in_last         = 1'b0;
        x0              = '0;
        w0              = '0;
        x1              = '0;
        w1              = '0;
        exp_front       = '0;
        run_total       = '0;
        pop_pending     = 1'b0;
        first_last_sent = 1'b0;
        exact_mode      = 1'b0;
        pulse_count     = 0;
        windows_sent    = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (5) idle_cycle();  // Quiet period after reset

        // Only the exact rows contribute here
        exact_mode = 1'b1;
        drive_beat(1'b1, 1'b1, 8'hc0, 8'hff, 8'h40, 8'h9b);
        drive_beat(1'b1, 1'b1, 8'h80, 8'h7e, 8'hc0, 8'h01);
        drive_beat(1'b1, 1'b1, 8'h40, 8'hff, 8'h80, 8'hff);

        // Zero operands on one side
        r = next_random();
        drive_beat(1'b1, 1'b0, 8'h00, r[7:0], 8'h00, r[15:8]);
        drive_beat(1'b1, 1'b1, 8'h00, r[23:16], 8'h00, r[31:24]);
        r = next_random();
        drive_beat(1'b1, 1'b0, r[7:0], 8'h00, r[15:8], 8'h00);
        drive_beat(1'b1, 1'b1, r[23:16], 8'h00, r[31:24], 8'h00);
        exact_mode = 1'b0;
        wait_drained(20);

        for (int n = 0; n < 200; n++) begin
            r = next_random();
            send_window(1 + int'(r % 32'd25), 3);
        end
        wait_drained(20);

        // Back-to-back windows with no idle cycle between them
        for (int n = 0; n < 30; n++) begin
            r = next_random();
            send_window(1 + int'(r % 32'd6), 0);
        end
        wait_drained(20);

        assert (pulse_count == windows_sent) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error($sformatf("[FAIL] pulse_count expected %h got %h",
                                    windows_sent, pulse_count));
        end
    end

endmodule
